// File: design/opl_types_pkg.sv
// shared types for the OPL register file: slot position, channel and operator words
// imported by every design module that carries these fields
package opl_types_pkg;

    typedef logic [1:0] group_t;    // channel group 0..2
    typedef logic [2:0] subslot_t;  // operator within group 0..5
    typedef logic [9:0] fnum_t;
    typedef logic [2:0] block_t;    // octave
    typedef logic [2:0] fb_t;       // modulator feedback
    typedef logic [3:0] rate_t;     // envelope rates and sustain level
    typedef logic [5:0] tl_t;       // total level

    typedef struct packed {
        group_t   group;
        subslot_t subslot;
        logic     op;               // carrier slot
        logic     zero;             // first slot of the round
    } slot_pos_t;

    typedef struct packed {
        logic   keyon;
        block_t block;
        fnum_t  fnum;
        fb_t    fb;
        logic   con;
    } ch_cfg_t;

    typedef struct packed {
        logic       amen;           // stage IV
        logic       viben;
        logic       en_sus;
        logic       ks;             // stage II
        logic [3:0] mul;            // stage II
        logic [1:0] ksl;            // stage IV
        tl_t        tl;             // stage IV
        rate_t      ar;
        rate_t      dr;
        rate_t      sl;
        rate_t      rr;
        logic [1:0] wav;
    } op_cfg_t;

    // one strobe per register bank
    typedef struct packed {
        logic fbcon;
        logic fnumlo;
        logic fnumhi;
        logic mult;
        logic ksl_tl;
        logic ar_dr;
        logic sl_rr;
        logic wav;
    } upd_t;

endpackage

// File: design/opl_regmap_pkg.sv
// register map and slot layout of the chip
package opl_regmap_pkg;

    localparam int SLOTS        = 18;
    localparam int GROUPS       = 3;
    localparam int SUBSLOTS     = 6;
    localparam int CH_PER_GROUP = 3;   // modulators first, then carriers
    localparam int CHANNELS     = 9;

    // bank base addresses
    localparam logic [7:0] ADDR_MULT   = 8'h20;
    localparam logic [7:0] ADDR_KSL_TL = 8'h40;
    localparam logic [7:0] ADDR_AR_DR  = 8'h60;
    localparam logic [7:0] ADDR_SL_RR  = 8'h80;
    localparam logic [7:0] ADDR_WAV    = 8'hE0;
    localparam logic [7:0] ADDR_FNUMLO = 8'hA0;
    localparam logic [7:0] ADDR_FNUMHI = 8'hB0;
    localparam logic [7:0] ADDR_FBCON  = 8'hC0;
    localparam logic [7:0] ADDR_RHYTHM = 8'hBD;

    // rhythm register bits
    localparam int RHY_EN_BIT = 5;
    localparam int RHY_BD     = 4;
    localparam int RHY_SD     = 3;
    localparam int RHY_TOM    = 2;
    localparam int RHY_TC     = 1;
    localparam int RHY_HH     = 0;

    // rhythm slot map
    localparam int RHY_SAMPLE_SLOT = 11;  // effective enable taken here
    localparam int RHY_LAST_SLOT   = 17;
    localparam int RHY_BD_SLOT0    = 12;  // bass drum keeps its connection
    localparam int RHY_BD_SLOT1    = 15;

endpackage

// File: design/opl_reg_decode.sv
// host side of the register file with address latch, write decode and the one pending update
// a data write waits here, with busy high, until the slot block reports done
module opl_reg_decode
    import opl_types_pkg::*, opl_regmap_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       addr,
    input  logic [7:0] din,
    input  logic       wr,
    input  logic       done,
    output upd_t       upd,
    output group_t     sel_group,
    output subslot_t   sel_sub,
    output logic [7:0] data,
    output logic       busy,
    output logic       rhy_en,
    output logic [4:0] rhy_kon
);

    logic [7:0] addr_q;
    upd_t       upd_dec;
    logic       op_bank, ch_bank, rhy_hit;
    logic       op_valid, ch_valid, accept;
    logic [3:0] ch_num, ch_grp, ch_rem;

    always_comb begin
        upd_dec        = '0;
        upd_dec.mult   = addr_q[7:5] == ADDR_MULT[7:5];
        upd_dec.ksl_tl = addr_q[7:5] == ADDR_KSL_TL[7:5];
        upd_dec.ar_dr  = addr_q[7:5] == ADDR_AR_DR[7:5];
        upd_dec.sl_rr  = addr_q[7:5] == ADDR_SL_RR[7:5];
        upd_dec.wav    = addr_q[7:5] == ADDR_WAV[7:5];
        upd_dec.fnumlo = addr_q[7:4] == ADDR_FNUMLO[7:4];
        upd_dec.fnumhi = addr_q[7:4] == ADDR_FNUMHI[7:4];
        upd_dec.fbcon  = addr_q[7:4] == ADDR_FBCON[7:4];
    end

    assign op_bank = upd_dec.mult | upd_dec.ksl_tl | upd_dec.ar_dr | upd_dec.sl_rr | upd_dec.wav;
    assign ch_bank = upd_dec.fnumlo | upd_dec.fnumhi | upd_dec.fbcon;
    assign rhy_hit = addr_q == ADDR_RHYTHM;    // 0xBD falls outside the channel range

    // channel c lives at group c/3 and modulator subslot c mod 3
    assign ch_num = addr_q[3:0];
    assign ch_grp = ch_num / 4'(CH_PER_GROUP);
    assign ch_rem = ch_num - ch_grp * 4'(CH_PER_GROUP);

    assign op_valid = op_bank && addr_q[2:0] < SUBSLOTS && addr_q[4:3] < GROUPS;
    assign ch_valid = ch_bank && ch_num < CHANNELS;
    assign accept   = wr && addr && !busy && (op_valid || ch_valid);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            addr_q  <= '0;
            busy    <= 1'b0;
            upd     <= '0;
            rhy_en  <= 1'b0;
            rhy_kon <= '0;
        end else if (done) begin
            busy <= 1'b0;
            upd  <= '0;
        end else if (wr && !busy) begin   // anything written while busy is lost
            if (!addr) begin
                addr_q <= din;
            end else if (rhy_hit) begin
                rhy_en  <= din[RHY_EN_BIT];
                rhy_kon <= din[4:0];
            end else if (accept) begin
                busy <= 1'b1;
                upd  <= upd_dec;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            data      <= '0;
            sel_group <= '0;
            sel_sub   <= '0;
        end else if (accept) begin
            data      <= din;
            sel_group <= op_valid ? addr_q[4:3] : ch_grp[1:0];
            sel_sub   <= op_valid ? addr_q[2:0] : ch_rem[2:0];
        end
    end

endmodule

// File: design/opl_op_csr.sv
// operator configuration of all slots in a circular shift register, one step per cen
// each field is rewritten at the stage where it leaves the register
module opl_op_csr
    import opl_types_pkg::*, opl_regmap_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] din,
    input  upd_t       upd,
    input  logic       update_i,
    input  logic       update_ii,
    input  logic       update_iv,
    output op_cfg_t    cfg
);

    op_cfg_t mem [SLOTS];
    op_cfg_t next;

    assign cfg = mem[SLOTS-1];

    always_comb begin
        next = cfg;
        if (update_i) begin
            if (upd.mult) begin
                next.viben  = din[6];
                next.en_sus = din[5];
            end
            if (upd.ar_dr) {next.ar, next.dr} = din;
            if (upd.sl_rr) {next.sl, next.rr} = din;
            if (upd.wav)   next.wav = din[1:0];
        end
        // the word at the output holds the previous slot's II fields
        if (update_ii && upd.mult) begin
            next.ks  = din[4];
            next.mul = din[3:0];
        end
        if (update_iv) begin
            if (upd.mult)   next.amen = din[7];
            if (upd.ksl_tl) {next.ksl, next.tl} = din;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < SLOTS; i++) begin
                mem[i] <= '0;
            end
        end else if (cen) begin
            mem[0] <= next;   // recirculate
            for (int i = 1; i < SLOTS; i++) begin
                mem[i] <= mem[i-1];
            end
        end
    end

endmodule

// File: design/opl_ch_delay.sv
// delay line holding the three channels of one group, advanced on cen
module opl_ch_delay
    import opl_types_pkg::*, opl_regmap_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  ch_cfg_t d,
    output ch_cfg_t q
);

    ch_cfg_t stage [CH_PER_GROUP];

    assign q = stage[CH_PER_GROUP-1];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CH_PER_GROUP; i++) begin
                stage[i] <= '0;
            end
        end else if (cen) begin
            stage[0] <= d;
            for (int i = 1; i < CH_PER_GROUP; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

endmodule

// File: design/opl_slot_regs.sv
// slot sequencer with operator and channel storage; streams each slot's parameters
// applies the pending host update as its slot passes, then pulses done
module opl_slot_regs
    import opl_types_pkg::*, opl_regmap_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  upd_t       upd,
    input  group_t     sel_group,
    input  subslot_t   sel_sub,
    input  logic [7:0] data,
    input  logic       busy,
    input  logic       rhy_en,
    input  logic [4:0] rhy_kon,
    output logic       done,
    output slot_pos_t  pos,
    output ch_cfg_t    ch,
    output op_cfg_t    op
);

    group_t           group, next_group;
    subslot_t         subslot, next_sub;
    logic [SLOTS-1:0] slot;            // one-hot slot index
    logic [4:0]       cur_id, id_ii, id_iii, id_iv, tgt_id;
    logic             match_i, match_ii, match_iv;
    logic             applied_i, applied_ii, applied_iv;
    ch_cfg_t          grp_q [GROUPS];
    ch_cfg_t          grp_d [GROUPS];
    ch_cfg_t          ch_cur, ch_new;
    op_cfg_t          op_cfg;
    logic [5:0]       rhy_csr;
    logic             rhy_oen;         // rhythm overrides active

    always_comb begin
        next_sub   = subslot + 3'd1;
        next_group = group;
        if (subslot == subslot_t'(SUBSLOTS-1)) begin
            next_sub   = '0;
            next_group = (group == group_t'(GROUPS-1)) ? '0 : group + 2'd1;
        end
    end

    assign cur_id = {group, subslot};
    assign tgt_id = {sel_group, sel_sub};

    // id_ii and id_iv: slots one and three cen ago, seeded with slots 17..15
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            group   <= '0;
            subslot <= '0;
            slot    <= {{(SLOTS-1){1'b0}}, 1'b1};
            id_ii   <= {group_t'(GROUPS-1), subslot_t'(SUBSLOTS-1)};
            id_iii  <= {group_t'(GROUPS-1), subslot_t'(SUBSLOTS-2)};
            id_iv   <= {group_t'(GROUPS-1), subslot_t'(SUBSLOTS-3)};
        end else if (cen) begin
            group   <= next_group;
            subslot <= next_sub;
            slot    <= {slot[SLOTS-2:0], slot[SLOTS-1]};
            id_ii   <= cur_id;
            id_iii  <= id_ii;
            id_iv   <= id_iii;
        end
    end

    // each stage takes the update once, in whatever order the slots come
    assign match_i  = busy && !applied_i && cur_id == tgt_id;
    assign match_ii = busy && !applied_ii && id_ii == tgt_id;
    assign match_iv = busy && !applied_iv && id_iv == tgt_id;
    assign done     = cen && busy && (applied_i || match_i) && (applied_ii || match_ii)
                      && (applied_iv || match_iv);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            applied_i  <= 1'b0;
            applied_ii <= 1'b0;
            applied_iv <= 1'b0;
        end else if (done) begin
            applied_i  <= 1'b0;
            applied_ii <= 1'b0;
            applied_iv <= 1'b0;
        end else if (cen) begin
            applied_i  <= applied_i | match_i;
            applied_ii <= applied_ii | match_ii;
            applied_iv <= applied_iv | match_iv;
        end
    end

    opl_op_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .din       (data),
        .upd       (upd),
        .update_i  (match_i),
        .update_ii (match_ii),
        .update_iv (match_iv),
        .cfg       (op_cfg)
    );

    // channel words, written at the modulator slot
    always_comb begin
        case (group)
            2'd1:    ch_cur = grp_q[1];
            2'd2:    ch_cur = grp_q[2];
            default: ch_cur = grp_q[0];
        endcase
        ch_new = ch_cur;
        if (match_i && upd.fnumlo) ch_new.fnum[7:0] = data;
        if (match_i && upd.fnumhi) {ch_new.keyon, ch_new.block, ch_new.fnum[9:8]} = data[5:0];
        if (match_i && upd.fbcon) begin
            ch_new.fb  = data[3:1];
            ch_new.con = data[0];
        end
        for (int g = 0; g < GROUPS; g++) begin
            grp_d[g] = (group == group_t'(g)) ? ch_new : grp_q[g];   // idle groups recirculate
        end
    end

    opl_ch_delay u_group0 (.clk(clk), .rst(rst), .cen(cen), .d(grp_d[0]), .q(grp_q[0]));
    opl_ch_delay u_group1 (.clk(clk), .rst(rst), .cen(cen), .d(grp_d[1]), .q(grp_q[1]));
    opl_ch_delay u_group2 (.clk(clk), .rst(rst), .cen(cen), .d(grp_d[2]), .q(grp_q[2]));

    // rhythm key-on order for slots 12..17, rotated to line up with the slot
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rhy_csr <= '0;
            rhy_oen <= 1'b0;
        end else if (cen) begin
            if (slot[RHY_SAMPLE_SLOT]) rhy_oen <= rhy_en;
            if (slot[RHY_LAST_SLOT]) begin
                rhy_csr <= {rhy_kon[RHY_BD], rhy_kon[RHY_HH], rhy_kon[RHY_TOM],
                            rhy_kon[RHY_BD], rhy_kon[RHY_SD], rhy_kon[RHY_TC]};
                rhy_oen <= 1'b0;
            end else begin
                rhy_csr <= {rhy_csr[4:0], rhy_csr[5]};
            end
        end
    end

    always_comb begin
        ch = ch_cur;
        op = op_cfg;
        if (rhy_oen) begin
            ch.keyon  = rhy_csr[5];
            op.en_sus = 1'b0;
            if (!slot[RHY_BD_SLOT0] && !slot[RHY_BD_SLOT1]) ch.con = 1'b1;
        end
    end

    assign pos.group   = group;
    assign pos.subslot = subslot;
    assign pos.op      = subslot >= subslot_t'(CH_PER_GROUP);
    assign pos.zero    = slot[0];

endmodule

// File: design/opl_regs_top.sv
// register file top: host decoder feeding the slot sequencer
// pos, ch and op stream one slot per cen
module opl_regs_top
    import opl_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       addr,
    input  logic [7:0] din,
    input  logic       wr,
    output logic       busy,
    output slot_pos_t  pos,
    output ch_cfg_t    ch,
    output op_cfg_t    op
);

    upd_t       upd;
    group_t     sel_group;
    subslot_t   sel_sub;
    logic [7:0] data;
    logic       done;
    logic       rhy_en;
    logic [4:0] rhy_kon;

    opl_reg_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .din       (din),
        .wr        (wr),
        .done      (done),
        .upd       (upd),
        .sel_group (sel_group),
        .sel_sub   (sel_sub),
        .data      (data),
        .busy      (busy),
        .rhy_en    (rhy_en),
        .rhy_kon   (rhy_kon)
    );

    opl_slot_regs u_slots (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .upd       (upd),
        .sel_group (sel_group),
        .sel_sub   (sel_sub),
        .data      (data),
        .busy      (busy),
        .rhy_en    (rhy_en),
        .rhy_kon   (rhy_kon),
        .done      (done),
        .pos       (pos),
        .ch        (ch),
        .op        (op)
    );

endmodule

// File: verification/tb_clock.sv
// free running testbench clock, period 20
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// File: verification/opl_regs_checker.sv
// register file model that mirrors host writes and compares each streamed slot
// counts checks and errors for the testbench top
module opl_regs_checker
    import opl_types_pkg::*, opl_regmap_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       addr,
    input  logic       wr,
    input  logic [7:0] din,
    input  logic       busy,
    input  slot_pos_t  pos,
    input  ch_cfg_t    ch,
    input  op_cfg_t    op,
    input  logic [2:0] test_id,
    output int         checks,
    output int         errors
);

    localparam int HOLD = 100;   // slot under a pending write

    op_cfg_t    op_m [SLOTS];
    ch_cfg_t    ch_m [CHANNELS];
    int         settle [SLOTS];
    int         cur, busy_cens, p_slot_a, p_slot_b;
    logic [7:0] a_q, p_addr, p_data;
    logic       p_valid, busy_q, rhy_en_m, eff, overlong;
    logic [4:0] rhy_kon_m, kon_snap;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "op_writes";
            3'd2:    return "ch_writes";
            3'd3:    return "invalid_busy";
            3'd4:    return "rhythm";
            default: return "reset_seq";
        endcase
    endfunction

    function automatic logic rhythm_key(input int s, input logic [4:0] k);
        case (s)
            12:      return k[RHY_BD];
            13:      return k[RHY_HH];
            14:      return k[RHY_TOM];
            15:      return k[RHY_BD];
            16:      return k[RHY_SD];
            default: return k[RHY_TC];
        endcase
    endfunction

    task automatic compare(input string field, input logic [33:0] exp, input logic [33:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s slot %0d expected %h actual %h",
                     test_name(test_id), field, cur, exp, act);
        end
    endtask

    task automatic check_outputs();
        int        p1;
        int        p3;
        int        c;
        slot_pos_t ep;
        op_cfg_t   e;
        ch_cfg_t   ec;
        p1 = (cur + SLOTS - 1) % SLOTS;
        p3 = (cur + SLOTS - 3) % SLOTS;
        c  = (cur / SUBSLOTS) * CH_PER_GROUP + (cur % SUBSLOTS) % CH_PER_GROUP;
        ep.group   = group_t'(cur / SUBSLOTS);
        ep.subslot = subslot_t'(cur % SUBSLOTS);
        ep.op      = (cur % SUBSLOTS) >= CH_PER_GROUP;
        ep.zero    = cur == 0;
        compare("pos", 34'(ep), 34'(pos));
        e  = op_m[cur];
        ec = ch_m[c];
        if (eff && cur >= 12) begin   // rhythm channels
            ec.keyon = rhythm_key(cur, kon_snap);
            e.en_sus = 1'b0;
            if (cur != 12 && cur != 15) ec.con = 1'b1;
        end
        if (settle[cur] == 0) begin
            compare("op_i", 34'({e.viben, e.en_sus, e.ar, e.dr, e.sl, e.rr, e.wav}),
                    34'({op.viben, op.en_sus, op.ar, op.dr, op.sl, op.rr, op.wav}));
            compare("ch", 34'(ec), 34'(ch));
        end
        if (settle[p1] == 0)
            compare("op_ii", 34'({op_m[p1].ks, op_m[p1].mul}), 34'({op.ks, op.mul}));
        if (settle[p3] == 0)
            compare("op_iv", 34'({op_m[p3].amen, op_m[p3].ksl, op_m[p3].tl}),
                    34'({op.amen, op.ksl, op.tl}));
    endtask

    task automatic apply_pending();
        int c;
        int s;
        c = int'(p_addr[3:0]);
        s = int'(p_addr[4:3]) * SUBSLOTS + int'(p_addr[2:0]);
        if (p_addr[7:4] == 4'hA) begin
            ch_m[c].fnum[7:0] = p_data;
        end else if (p_addr[7:4] == 4'hB) begin
            {ch_m[c].keyon, ch_m[c].block, ch_m[c].fnum[9:8]} = p_data[5:0];
        end else if (p_addr[7:4] == 4'hC) begin
            ch_m[c].fb  = p_data[3:1];
            ch_m[c].con = p_data[0];
        end else begin
            case (p_addr[7:5])
                3'h1: {op_m[s].amen, op_m[s].viben, op_m[s].en_sus, op_m[s].ks,
                       op_m[s].mul} = p_data;
                3'h2: {op_m[s].ksl, op_m[s].tl} = p_data;
                3'h3: {op_m[s].ar, op_m[s].dr} = p_data;
                3'h4: {op_m[s].sl, op_m[s].rr} = p_data;
                default: op_m[s].wav = p_data[1:0];
            endcase
        end
        settle[p_slot_a] = 2;   // seen from the second visit on
        if (p_slot_b >= 0) settle[p_slot_b] = 2;
        p_valid = 1'b0;
    endtask

    task automatic decode_write();
        logic is_op;
        logic is_ch;
        is_op = a_q[7:5] inside {3'h1, 3'h2, 3'h3, 3'h4, 3'h7};
        is_ch = a_q[7:4] inside {4'hA, 4'hB, 4'hC};
        if (!addr) begin
            a_q = din;
        end else if (a_q == ADDR_RHYTHM) begin
            rhy_en_m  = din[RHY_EN_BIT];
            rhy_kon_m = din[4:0];
        end else if ((is_op && a_q[2:0] < 3'd6 && a_q[4:3] < 2'd3) ||
                     (is_ch && a_q[3:0] < 4'd9)) begin
            p_valid = 1'b1;
            p_addr  = a_q;
            p_data  = din;
            if (is_op) begin
                p_slot_a = int'(a_q[4:3]) * SUBSLOTS + int'(a_q[2:0]);
                p_slot_b = -1;
            end else begin
                p_slot_a = (int'(a_q[3:0]) / 3) * SUBSLOTS + int'(a_q[3:0]) % 3;
                p_slot_b = p_slot_a + CH_PER_GROUP;   // carrier of the channel
            end
            settle[p_slot_a] = HOLD;
            if (p_slot_b >= 0) settle[p_slot_b] = HOLD;
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < SLOTS; i++) begin
                op_m[i]   = '0;
                settle[i] = 0;
            end
            for (int i = 0; i < CHANNELS; i++) ch_m[i] = '0;
            cur = 0;
            busy_cens = 0;
            a_q = '0;
            p_valid = 1'b0;
            busy_q = 1'b0;
            rhy_en_m = 1'b0;
            rhy_kon_m = '0;
            kon_snap = '0;
            eff = 1'b0;
            overlong = 1'b0;
            checks = 0;
            errors = 0;
        end else begin
            if (cen) check_outputs();
            if (p_valid && !busy && !busy_q) begin
                errors++;
                $display("ERROR %s busy did not rise after a valid write", test_name(test_id));
                p_valid = 1'b0;
            end
            if (busy && !p_valid) begin
                errors++;
                $display("ERROR %s busy is high with no write pending", test_name(test_id));
            end
            if (busy && cen) busy_cens++;
            if (!busy) begin
                busy_cens = 0;
                overlong  = 1'b0;
            end else if (busy_cens > SLOTS && !overlong) begin
                overlong = 1'b1;
                errors++;
                $display("ERROR %s busy stayed high for more than 18 cen pulses",
                         test_name(test_id));
            end
            if (cen) begin
                if (settle[cur] == 1 || settle[cur] == 2) settle[cur]--;
                if (cur == 11) eff = rhy_en_m;
                if (cur == 17) begin
                    kon_snap = rhy_kon_m;
                    eff      = 1'b0;
                end
                cur = (cur + 1) % SLOTS;
            end
            if (busy_q && !busy && p_valid) apply_pending();
            if (wr && !busy) decode_write();
            busy_q = busy;
        end
    end

endmodule

// File: verification/opl_regs_properties.sv
// sequencer and busy rules bound into the slot register block
module opl_regs_properties
    import opl_types_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input slot_pos_t pos,
    input logic      done,
    input logic      busy
);

    a_range : assert property (@(posedge clk) disable iff (rst)
        pos.subslot < 3'd6 && pos.group < 2'd3)
        else $error("slot position out of range");

    a_zero : assert property (@(posedge clk) disable iff (rst)
        pos.zero |-> (pos.group == 2'd0 && pos.subslot == 3'd0))
        else $error("zero flag away from slot 0");

    a_done : assert property (@(posedge clk) disable iff (rst) done |=> !busy)
        else $error("busy still high after done");

endmodule

bind opl_slot_regs opl_regs_properties u_props (
    .clk  (clk),
    .rst  (rst),
    .pos  (pos),
    .done (done),
    .busy (busy)
);

// File: verification/tb_opl_regs.sv
// testbench top with reset, random cen and random host register writes
// the checker compares every streamed slot against its model
module tb_opl_regs
    import opl_types_pkg::*, opl_regmap_pkg::*;
;

    logic       clk, rst, cen, addr, wr, busy;
    logic [7:0] din;
    logic [2:0] test_id;
    slot_pos_t  pos;
    ch_cfg_t    ch;
    op_cfg_t    op;
    int         checks, errors, cen_seen, last_checks, last_errors;
    integer     seed;

    tb_clock u_clock (.clk(clk));

    opl_regs_top uut (
        .clk(clk), .rst(rst), .cen(cen), .addr(addr), .din(din), .wr(wr),
        .busy(busy), .pos(pos), .ch(ch), .op(op)
    );

    opl_regs_checker u_check (
        .clk(clk), .rst(rst), .cen(cen), .addr(addr), .wr(wr), .din(din),
        .busy(busy), .pos(pos), .ch(ch), .op(op), .test_id(test_id),
        .checks(checks), .errors(errors)
    );

    function automatic int next_rand();
        return $random(seed);
    endfunction

    // one clock with cen high on about half of the cycles
    task automatic tick();
        int r;
        @(posedge clk);
        if (cen) cen_seen++;
        r = next_rand();
        cen <= r[0];
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
        tick();
        addr <= 1'b0;
        din  <= a;
        wr   <= 1'b1;
        tick();
        addr <= 1'b1;
        din  <= d;
        tick();
        wr   <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            n++;
            if (n > 400) abort_on_timeout("busy to fall");
            tick();
            @(negedge clk);
        end
    endtask

    task automatic run_cens(input int count);
        int start;
        int n;
        start = cen_seen;
        n = 0;
        while (cen_seen - start < count) begin
            tick();
            n++;
            if (n > 40 * count + 100) abort_on_timeout("cen pulses");
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        $display("test %s done: %0d checks, %0d errors", name,
                 checks - last_checks, errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    function automatic logic [7:0] op_addr(input int bank, input logic [4:0] off);
        case (bank % 5)
            0:       return ADDR_MULT | 8'(off);
            1:       return ADDR_KSL_TL | 8'(off);
            2:       return ADDR_AR_DR | 8'(off);
            3:       return ADDR_SL_RR | 8'(off);
            default: return ADDR_WAV | 8'(off);
        endcase
    endfunction

    function automatic logic [7:0] ch_addr(input int bank, input logic [3:0] c);
        case (bank % 3)
            0:       return ADDR_FNUMLO | 8'(c);
            1:       return ADDR_FNUMHI | 8'(c);
            default: return ADDR_FBCON | 8'(c);
        endcase
    endfunction

    initial begin
        int          r;
        logic [7:0]  a;
        seed = 32'hb233_fa04;
        rst = 1'b1;
        cen = 1'b0;
        addr = 1'b0;
        wr = 1'b0;
        din = '0;
        test_id = 3'd0;
        cen_seen = 0;
        last_checks = 0;
        last_errors = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        run_cens(40);
        finish_test("reset_seq");

        test_id = 3'd1;
        repeat (60) begin
            r = next_rand();
            a = op_addr($unsigned(r) % 5,
                        {2'($unsigned(r[15:8]) % 3), 3'($unsigned(r[31:16]) % 6)});
            write_reg(a, 8'(next_rand()));
            wait_idle();
        end
        run_cens(40);
        finish_test("op_writes");

        test_id = 3'd2;
        repeat (40) begin
            r = next_rand();
            write_reg(ch_addr($unsigned(r) % 3, 4'($unsigned(r[31:16]) % 9)), 8'(next_rand()));
            wait_idle();
        end
        run_cens(40);
        finish_test("ch_writes");

        test_id = 3'd3;
        repeat (40) begin
            r = next_rand();
            a = r[20] ? op_addr($unsigned(r) % 5, r[12:8]) : ch_addr($unsigned(r) % 3, r[11:8]);
            write_reg(a, 8'(next_rand()));
            r = next_rand();
            write_reg(op_addr($unsigned(r) % 5, r[12:8]), 8'(next_rand()));   // likely dropped
            wait_idle();
        end
        run_cens(40);
        finish_test("invalid_busy");

        test_id = 3'd4;
        write_reg(ADDR_RHYTHM, {2'b00, 1'b1, 5'(next_rand())});
        run_cens(60);
        repeat (4) begin
            r = next_rand();
            write_reg(ADDR_RHYTHM, {2'b00, r[8], r[4:0]});
            run_cens(40);
        end
        write_reg(ADDR_RHYTHM, 8'h00);
        run_cens(40);
        finish_test("rhythm");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
design/opl_types_pkg.sv
design/opl_regmap_pkg.sv
design/opl_reg_decode.sv
design/opl_op_csr.sv
design/opl_ch_delay.sv
design/opl_slot_regs.sv
design/opl_regs_top.sv
verification/tb_clock.sv
verification/opl_regs_checker.sv
verification/opl_regs_properties.sv
verification/tb_opl_regs.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide on the log contents

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_opl_regs \
    -f compile.f -o sim_opl_regs > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_opl_regs > sim.log 2>&1 || echo "Test FAILED" >> sim.log

cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
